// File: hdl/decode_settings.svh
// Widths, FIFO depth, RV32I opcodes and ALU operation codes for the decode stage
// Included by the package and by every module that needs a raw constant

`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////
`define XLEN         32  // Data and address width
`define REG_ADDR_W   5   // x0..x31
`define ALU_OP_W     4   // {bit 30, funct3}
`define LSU_CTRL_W   4   // {store, funct3}

`define FIFO_DEPTH   4   // Decoded entries between decoder and issue

////////////////////////////////////////////////////////////
// Opcodes of the kept instruction groups
////////////////////////////////////////////////////////////
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP       7'b0110011
`define OPC_OPIMM    7'b0010011
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111

// ALU codes
`define ALU_OP_ADD   4'b0000
`define F3_SLL       3'b001  // Shift left
`define F3_SRX       3'b101  // Shift right, logical or arithmetic

`endif

// File: hdl/decode_pkg.sv
// Types shared by the decoder, the entry FIFO and the issue controller
// Modules pull these in with a wildcard import in their header

`include "decode_settings.svh"

package decode_pkg;

  // Plain vectors with a meaning
  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`ALU_OP_W-1:0]   alu_op_t;
  typedef logic [`LSU_CTRL_W-1:0] lsu_ctrl_t;

  // Kept instruction groups, illegal opcodes never get an entry
  typedef enum logic [2:0] {
    CLASS_ALU_REG = 3'd0,
    CLASS_ALU_IMM = 3'd1,
    CLASS_UPPER   = 3'd2,  // LUI and AUIPC
    CLASS_LOAD    = 3'd3,
    CLASS_STORE   = 3'd4
  } instr_class_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_STALL = 2'd1,  // One bubble for a RAW hazard
    ST_ADDR  = 2'd2,  // Address strobe out, LSU request being built
    ST_LSU   = 2'd3   // LSU request out
  } issue_state_e;

  ////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    instr_class_e instr_class;
    alu_op_t      alu_op;
    reg_addr_t    rd;        // Zero for a store
    reg_addr_t    rs1;       // Zero when not read
    reg_addr_t    rs2;       // Zero when not read
    xlen_t        imm;       // Already sign extended
    logic         use_pc;
    logic         use_imm;
    lsu_ctrl_t    lsu_ctrl;
    xlen_t        pc;
  } decoded_instr_t;

  typedef struct packed {
    logic      valid;
    alu_op_t   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_pc;   // Operand A is the pc
    logic      use_imm;  // Operand B is imm
    xlen_t     imm;
    xlen_t     pc;
    reg_addr_t rd;
    logic      wb;       // Write result to rd
  } alu_ctrl_t;

  typedef struct packed {
    logic      valid;
    lsu_ctrl_t lsu_ctrl;
    reg_addr_t rd;   // Load target
    reg_addr_t rs2;  // Store data source
  } lsu_req_t;

endpackage

// File: hdl/instr_field_decoder.sv
// Producer side of the decode stage
// Splits a strobed RV32I word into fields and immediates and writes one
// decoded entry, or pulses the illegal flag, one cycle after the strobe

`timescale 1ns/10ps

`include "decode_settings.svh"

module instr_field_decoder import decode_pkg::*; (
  input  logic           clk_i,
  input  logic           rstn_i,
  input  logic           instr_valid_i,
  input  xlen_t          instr_i,
  input  xlen_t          instr_addr_i,
  output decoded_instr_t entry_o,
  output logic           entry_we_o,
  output logic           illegal_instr_o
);

  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic [6:0]     funct7;
  reg_addr_t      rd;
  reg_addr_t      rs1;
  reg_addr_t      rs2;
  xlen_t          imm_i;
  xlen_t          imm_s;
  xlen_t          imm_u;
  xlen_t          imm_shamt;
  logic           is_shift;
  logic           legal;
  decoded_instr_t entry_d;

  ////////////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////////////
  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  assign imm_i     = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u     = {instr_i[31:12], 12'b0};
  assign imm_shamt = {27'b0, instr_i[24:20]};  // Shift amount only

  assign is_shift = (funct3 == `F3_SLL) || (funct3 == `F3_SRX);

  ////////////////////////////////////////////////////////////
  // Classification
  ////////////////////////////////////////////////////////////
  always_comb begin
    entry_d        = '0;  // Unread sources stay x0
    entry_d.pc     = instr_addr_i;
    entry_d.alu_op = `ALU_OP_ADD;
    legal          = 1'b1;

    case (opcode)
      `OPC_OP: begin
        entry_d.instr_class = CLASS_ALU_REG;
        entry_d.alu_op      = {funct7[5], funct3};  // Bit 30 picks SUB and SRA
        entry_d.rd          = rd;
        entry_d.rs1         = rs1;
        entry_d.rs2         = rs2;
      end
      `OPC_OPIMM: begin
        entry_d.instr_class = CLASS_ALU_IMM;
        entry_d.rd          = rd;
        entry_d.rs1         = rs1;
        entry_d.use_imm     = 1'b1;
        if (is_shift) begin
          entry_d.imm    = imm_shamt;
          entry_d.alu_op = {funct7[5], funct3};
        end else begin
          entry_d.imm    = imm_i;
          entry_d.alu_op = {1'b0, funct3};  // Bit 30 is immediate here
        end
      end
      `OPC_LUI, `OPC_AUIPC: begin
        // Added to x0, or to the pc for AUIPC
        entry_d.instr_class = CLASS_UPPER;
        entry_d.rd          = rd;
        entry_d.imm         = imm_u;
        entry_d.use_imm     = 1'b1;
        entry_d.use_pc      = (opcode == `OPC_AUIPC);
      end
      `OPC_LOAD: begin
        entry_d.instr_class = CLASS_LOAD;
        entry_d.rd          = rd;
        entry_d.rs1         = rs1;
        entry_d.imm         = imm_i;
        entry_d.use_imm     = 1'b1;
        entry_d.lsu_ctrl    = {opcode[5], funct3};
      end
      `OPC_STORE: begin
        entry_d.instr_class = CLASS_STORE;
        entry_d.rs1         = rs1;
        entry_d.rs2         = rs2;  // Data source
        entry_d.imm         = imm_s;
        entry_d.use_imm     = 1'b1;
        entry_d.lsu_ctrl    = {opcode[5], funct3};
      end
      default: legal = 1'b0;  // Branches, jumps, FENCE, SYSTEM and unknown
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      entry_we_o      <= 1'b0;
      illegal_instr_o <= 1'b0;
    end else begin
      entry_we_o      <= instr_valid_i & legal;
      illegal_instr_o <= instr_valid_i & ~legal;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      entry_o <= entry_d;
    end
  end

endmodule

// File: hdl/decoded_instr_fifo.sv
// Circular buffer of decoded entries between decoder and issue controller
// Head entry is shown combinationally; a write to a full buffer is lost and
// raises a sticky overflow flag

`timescale 1ns/10ps

`include "decode_settings.svh"

module decoded_instr_fifo import decode_pkg::*; (
  input  logic           clk_i,
  input  logic           rstn_i,
  input  logic           wr_i,
  input  decoded_instr_t wr_entry_i,
  input  logic           rd_i,
  output decoded_instr_t rd_entry_o,
  output logic           empty_o,
  output logic           overflow_o
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  decoded_instr_t   mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full       = (count_q == CNT_W'(`FIFO_DEPTH));
  assign empty_o    = (count_q == '0);
  assign do_wr      = wr_i & ~full;
  assign do_rd      = rd_i & ~empty_o;
  assign rd_entry_o = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= wr_entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_wr) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_rd) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (do_wr && !do_rd) begin
        count_q <= count_q + 1'b1;
      end else if (!do_wr && do_rd) begin
        count_q <= count_q - 1'b1;
      end
      if (wr_i && full) overflow_o <= 1'b1;  // Held until reset
    end
  end

endmodule

// File: hdl/issue_control.sv
// Consumer side of the decode stage
// Pops one entry at a time, adds a bubble on a RAW hazard against the last
// issued rd and drives registered ALU and LSU control strobes

`timescale 1ns/10ps

module issue_control import decode_pkg::*; (
  input  logic           clk_i,
  input  logic           rstn_i,
  input  decoded_instr_t head_i,
  input  logic           empty_i,
  output logic           pop_o,
  output alu_ctrl_t      alu_ctrl_o,
  output lsu_req_t       lsu_req_o
);

  issue_state_e   state_q;
  issue_state_e   state_d;
  decoded_instr_t entry_q;    // Entry in flight after the pop
  decoded_instr_t cur;
  reg_addr_t      last_rd_q;  // Destination of the last issued instruction
  reg_addr_t      last_rd_d;
  alu_ctrl_t      alu_d;
  lsu_req_t       lsu_d;
  logic           hazard;
  logic           issue_go;
  logic           is_mem;

  assign pop_o = (state_q == ST_IDLE) && !empty_i;

  // Head is used directly in the pop cycle
  assign cur    = (state_q == ST_IDLE) ? head_i : entry_q;
  assign is_mem = (cur.instr_class == CLASS_LOAD) || (cur.instr_class == CLASS_STORE);

  // x0 never creates a dependency
  assign hazard = ((cur.rs1 != '0) && (cur.rs1 == last_rd_q)) ||
                  ((cur.rs2 != '0) && (cur.rs2 == last_rd_q));

  ////////////////////////////////////////////////////////////
  // Next state and next outputs
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d   = state_q;
    last_rd_d = last_rd_q;
    issue_go  = 1'b0;
    alu_d     = '0;
    lsu_d     = '0;

    case (state_q)
      ST_IDLE: begin
        if (!empty_i) begin
          if (hazard) begin
            state_d = ST_STALL;
          end else begin
            issue_go = 1'b1;
          end
        end
      end
      ST_STALL: issue_go = 1'b1;  // Bubble done so the held entry issues
      ST_ADDR: begin
        lsu_d.valid    = 1'b1;
        lsu_d.lsu_ctrl = cur.lsu_ctrl;
        lsu_d.rd       = cur.rd;   // x0 for a store
        lsu_d.rs2      = cur.rs2;  // x0 for a load
        last_rd_d      = cur.rd;
        state_d        = ST_LSU;
      end
      ST_LSU:  state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase

    // First strobe of an entry
    if (issue_go) begin
      alu_d.valid   = 1'b1;
      alu_d.alu_op  = cur.alu_op;  // Add for loads, stores and upper immediates
      alu_d.rs1     = cur.rs1;
      alu_d.use_pc  = cur.use_pc;
      alu_d.use_imm = cur.use_imm;
      alu_d.imm     = cur.imm;
      alu_d.pc      = cur.pc;
      if (is_mem) begin
        state_d = ST_ADDR;  // Address step without writeback
      end else begin
        alu_d.rs2 = cur.rs2;
        alu_d.rd  = cur.rd;
        alu_d.wb  = 1'b1;
        last_rd_d = cur.rd;
        state_d   = ST_IDLE;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      state_q   <= ST_IDLE;
      last_rd_q <= '0;
    end else begin
      state_q   <= state_d;
      last_rd_q <= last_rd_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      entry_q <= head_i;
    end
  end

  // Registered ALU and LSU strobes with their payload
  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      alu_ctrl_o.valid <= 1'b0;
      lsu_req_o.valid  <= 1'b0;
    end else begin
      alu_ctrl_o <= alu_d;
      lsu_req_o  <= lsu_d;
    end
  end

endmodule

// File: hdl/rv32i_decode_top.sv
// Top of the restructured RV32I decode stage
// Field decoder feeds the entry FIFO, the issue controller drains it and
// drives the ALU and LSU control strobes

`timescale 1ns/10ps

module rv32i_decode_top import decode_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,  // One-cycle strobe, no ready
  input  xlen_t     instr_i,
  input  xlen_t     instr_addr_i,
  output alu_ctrl_t alu_ctrl_o,
  output lsu_req_t  lsu_req_o,
  output logic      illegal_instr_o,
  output logic      overflow_o      // Sticky until reset
);

  decoded_instr_t dec_entry;
  logic           dec_we;
  decoded_instr_t head_entry;
  logic           fifo_empty;
  logic           issue_pop;

  instr_field_decoder u_decoder (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .instr_addr_i    (instr_addr_i),
    .entry_o         (dec_entry),
    .entry_we_o      (dec_we),
    .illegal_instr_o (illegal_instr_o)
  );

  decoded_instr_fifo u_fifo (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .wr_i       (dec_we),
    .wr_entry_i (dec_entry),
    .rd_i       (issue_pop),
    .rd_entry_o (head_entry),
    .empty_o    (fifo_empty),
    .overflow_o (overflow_o)
  );

  issue_control u_issue (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .head_i     (head_entry),
    .empty_i    (fifo_empty),
    .pop_o      (issue_pop),
    .alu_ctrl_o (alu_ctrl_o),
    .lsu_req_o  (lsu_req_o)
  );

endmodule

// File: testbench/decode_tb_model.svh
// Reference side of the decode testbench
// LFSR source, RV32I encoders and the expected ALU and LSU control per
// instruction; included inside the testbench module

`ifndef DECODE_TB_MODEL_SVH
`define DECODE_TB_MODEL_SVH

logic [15:0] lfsr_q = 16'd12826;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_q[0]};
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
  end
  return r;
endfunction

function automatic reg_addr_t rand_reg();
  logic [31:0] r;
  r = rand_bits(5);
  return r[4:0];
endfunction

function automatic logic [11:0] rand_imm12();
  logic [31:0] r;
  r = rand_bits(12);
  return r[11:0];
endfunction

function automatic xlen_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic xlen_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic xlen_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

////////////////////////////////////////////////////////////
// Expected control
////////////////////////////////////////////////////////////
function automatic alu_ctrl_t model_alu(input xlen_t ins, input xlen_t pc);
  alu_ctrl_t a;
  logic [2:0] f3;
  a = '0;
  f3 = ins[14:12];
  a.valid = 1'b1;
  a.pc = pc;
  a.use_imm = 1'b1;
  case (ins[6:0])
    7'b0110011: begin  // OP
      a.alu_op = {ins[30], f3};
      a.use_imm = 1'b0;
      a.rs1 = ins[19:15];
      a.rs2 = ins[24:20];
    end
    7'b0010011: begin  // OP-IMM
      a.rs1 = ins[19:15];
      if (f3 == 3'b001 || f3 == 3'b101) begin
        a.alu_op = {ins[30], f3};
        a.imm = {27'b0, ins[24:20]};
      end else begin
        a.alu_op = {1'b0, f3};
        a.imm = {{20{ins[31]}}, ins[31:20]};
      end
    end
    7'b0110111: a.imm = {ins[31:12], 12'b0};
    7'b0010111: begin
      a.imm = {ins[31:12], 12'b0};
      a.use_pc = 1'b1;
    end
    7'b0000011: begin
      a.rs1 = ins[19:15];
      a.imm = {{20{ins[31]}}, ins[31:20]};
    end
    7'b0100011: begin
      a.rs1 = ins[19:15];
      a.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    end
    default: a = '0;
  endcase
  // Address steps carry no destination
  if (a.valid && ins[6:0] != 7'b0000011 && ins[6:0] != 7'b0100011) begin
    a.rd = ins[11:7];
    a.wb = 1'b1;
  end
  return a;
endfunction

function automatic lsu_req_t model_lsu(input xlen_t ins);
  lsu_req_t l;
  l = '0;
  if (ins[6:0] == 7'b0000011 || ins[6:0] == 7'b0100011) begin
    l.valid = 1'b1;
    l.lsu_ctrl = {ins[5], ins[14:12]};
    if (ins[5]) l.rs2 = ins[24:20];
    else l.rd = ins[11:7];
  end
  return l;
endfunction

// Sources actually read, x0 otherwise
function automatic logic reads_rs1(input xlen_t ins);
  return ins[6:0] inside {7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011};
endfunction

function automatic logic reads_rs2(input xlen_t ins);
  return ins[6:0] inside {7'b0110011, 7'b0100011};
endfunction

`endif

// File: testbench/decode_tb.sv
// Testbench for the RV32I decode stage
// Drives instructions on the falling edge, checks every ALU and LSU strobe
// against reference values and reports each test and the final counts

`timescale 1ns/10ps

module decode_tb import decode_pkg::*; ();

  logic      clk_i;
  logic      rstn_i;
  logic      instr_valid_i;
  xlen_t     instr_i;
  xlen_t     instr_addr_i;
  alu_ctrl_t alu_ctrl_o;
  lsu_req_t  lsu_req_o;
  logic      illegal_instr_o;
  logic      overflow_o;

  alu_ctrl_t exp_alu_q[$];
  lsu_req_t  exp_lsu_q[$];
  int        bound_q[$];   // Issue cycle of each ALU strobe
  int        cycle_cnt = 0;
  int        last_alu = -10;
  int        errors = 0;
  int        checks = 0;
  int        tests = 0;
  int        exp_illegal = 0;
  int        seen_illegal = 0;
  int        err_start = 0;
  logic      check_en = 1'b0;
  reg_addr_t prev_rd = '0;
  xlen_t     pc_q = 32'h0000_1000;

  `include "decode_tb_model.svh"

  rv32i_decode_top dut (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .instr_addr_i    (instr_addr_i),
    .alu_ctrl_o      (alu_ctrl_o),
    .lsu_req_o       (lsu_req_o),
    .illegal_instr_o (illegal_instr_o),
    .overflow_o      (overflow_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;
  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  ////////////////////////////////////////////////////////////
  // Output checker sampled mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge clk_i) begin
    if (rstn_i && check_en) begin
      if (alu_ctrl_o.valid) begin
        if (exp_alu_q.size() == 0) begin
          errors++;
          $display("ALU strobe at %0t with no instruction left to issue", $time);
        end else begin
          checks++;
          assert (alu_ctrl_o == exp_alu_q[0]) else begin
            errors++;
            $display("CHECK FAILED %0t alu_ctrl_o exp %h got %h", $time, exp_alu_q[0], alu_ctrl_o);
          end
          assert (cycle_cnt == bound_q[0]) else begin
            errors++;
            $display("ALU strobe at %0t did not come in the cycle the issue timing gives",
                     $time);
          end
          void'(exp_alu_q.pop_front());
          void'(bound_q.pop_front());
        end
        last_alu = cycle_cnt;
      end
      if (lsu_req_o.valid) begin
        if (exp_lsu_q.size() == 0) begin
          errors++;
          $display("LSU request at %0t with no memory instruction pending", $time);
        end else begin
          checks++;
          assert (lsu_req_o == exp_lsu_q[0]) else begin
            errors++;
            $display("CHECK FAILED %0t lsu_req_o exp %h got %h", $time, exp_lsu_q[0], lsu_req_o);
          end
          assert (cycle_cnt == last_alu + 1) else begin
            errors++;
            $display("LSU request at %0t did not follow its address step by one cycle",
                     $time);
          end
          void'(exp_lsu_q.pop_front());
        end
      end
      if (illegal_instr_o) seen_illegal++;
    end
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %0t %s exp %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rstn_i = 1'b0;
    instr_valid_i = 1'b0;
    repeat (2) @(negedge clk_i);
    rstn_i = 1'b1;
    prev_rd = '0;
    exp_alu_q.delete();
    exp_lsu_q.delete();
    bound_q.delete();
  endtask

  // One strobe and three quiet cycles
  task automatic send_instr(input xlen_t ins);
    alu_ctrl_t a;
    lsu_req_t  l;
    logic      haz;
    a = model_alu(ins, pc_q);
    l = model_lsu(ins);
    haz = (reads_rs1(ins) && ins[19:15] != '0 && ins[19:15] == prev_rd) ||
          (reads_rs2(ins) && ins[24:20] != '0 && ins[24:20] == prev_rd);
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    instr_i = ins;
    instr_addr_i = pc_q;
    if (a.valid) begin
      exp_alu_q.push_back(a);
      bound_q.push_back(cycle_cnt + (haz ? 4 : 3));
      prev_rd = (ins[6:0] == 7'b0100011) ? '0 : ins[11:7];
    end else begin
      exp_illegal++;
    end
    if (l.valid) exp_lsu_q.push_back(l);
    pc_q = pc_q + 32'd4;
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while ((exp_alu_q.size() != 0 || exp_lsu_q.size() != 0) && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= 200) begin
      errors++;
      $display("Timed out waiting for the expected strobes in %s", name);
    end
    repeat (4) @(negedge clk_i);
    checks++;
    assert (seen_illegal == exp_illegal) else begin
      errors++;
      $display("CHECK FAILED %0t illegal_instr_o pulses exp %0d got %0d",
               $time, exp_illegal, seen_illegal);
    end
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_start);
    err_start = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    logic [2:0]  f3;
    logic        b30;
    reg_addr_t   r;
    logic [31:0] rb;
    int          n;
    rstn_i = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = '0;
    instr_addr_i = '0;
    apply_reset();
    check_en = 1'b1;

    // Random ALU-class instructions
    for (int i = 0; i < 30; i++) begin
      rb = rand_bits(3);
      f3 = rb[2:0];
      rb = rand_bits(1);
      b30 = rb[0];
      case (i % 5)
        0: send_instr(enc_r({1'b0, b30 & (f3 == 3'b000 || f3 == 3'b101), 5'b0},
                            rand_reg(), rand_reg(), f3, rand_reg()));
        1: send_instr(enc_i(rand_imm12(), rand_reg(), (f3 == 3'b001) ? 3'b000 : f3,
                            rand_reg(), 7'b0010011));
        2: send_instr(enc_i({1'b0, b30 & f3[2], 5'b0, rand_reg()}, rand_reg(),
                            f3[2] ? 3'b101 : 3'b001, rand_reg(), 7'b0010011));
        3: begin
          rb = rand_bits(20);
          send_instr({rb[19:0], rand_reg(), 7'b0110111});
        end
        default: begin
          rb = rand_bits(20);
          send_instr({rb[19:0], rand_reg(), 7'b0010111});
        end
      endcase
    end
    end_test("alu classes");

    // Loads and stores
    for (int i = 0; i < 12; i++) begin
      rb = rand_bits(3);
      f3 = rb[2:0];
      if (i % 2 == 0) send_instr(enc_i(rand_imm12(), rand_reg(), f3, rand_reg(), 7'b0000011));
      else send_instr(enc_s(rand_imm12(), rand_reg(), rand_reg(), f3));
    end
    end_test("load store");

    // Read-after-write pairs and independent pairs
    for (int i = 0; i < 6; i++) begin
      r = rand_reg() | 5'd1;
      send_instr(enc_i(rand_imm12(), rand_reg(), 3'b000, r, 7'b0010011));
      send_instr(enc_r(7'b0, rand_reg(), r, 3'b000, rand_reg()));
      send_instr(enc_i(rand_imm12(), rand_reg(), 3'b010, r, 7'b0000011));
      send_instr(enc_s(rand_imm12(), r, 5'd0, 3'b010));
      send_instr(enc_i(rand_imm12(), r, 3'b000, 5'd0, 7'b0010011));
      send_instr(enc_r(7'b0, 5'd0, 5'd0, 3'b111, r ^ 5'd1));
    end
    end_test("raw stall");

    // Dropped opcodes
    rb = rand_bits(25);
    send_instr({rb[24:0], 7'b1100011});
    rb = rand_bits(25);
    send_instr({rb[24:0], 7'b1101111});
    rb = rand_bits(25);
    send_instr({rb[24:0], 7'b1110011});
    rb = rand_bits(25);
    send_instr({rb[24:0], 7'b1111111});
    send_instr(32'h0000_0000);
    end_test("illegal opcodes");

    // Loads take three issue cycles each so a burst fills the FIFO
    check_en = 1'b0;
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    instr_i = enc_i(12'h010, 5'd3, 3'b010, 5'd4, 7'b0000011);
    repeat (10) @(negedge clk_i);
    instr_valid_i = 1'b0;
    n = 0;
    while (!overflow_o && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    check_bit("overflow_o", 1'b1, overflow_o);
    repeat (8) @(negedge clk_i);
    check_bit("overflow_o", 1'b1, overflow_o);
    apply_reset();
    check_bit("overflow_o", 1'b0, overflow_o);
    check_bit("alu_ctrl_o.valid", 1'b0, alu_ctrl_o.valid);
    check_bit("lsu_req_o.valid", 1'b0, lsu_req_o.valid);
    check_bit("illegal_instr_o", 1'b0, illegal_instr_o);
    check_en = 1'b1;
    end_test("overflow and reset");

    $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hdl
+incdir+testbench
hdl/decode_pkg.sv
hdl/instr_field_decoder.sv
hdl/decoded_instr_fifo.sv
hdl/issue_control.sv
hdl/rv32i_decode_top.sv
testbench/decode_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module decode_tb -o decode_sim \
  > build.log 2>&1 && ./obj_dir/decode_sim > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" || {
  echo "simulation failed, see build.log and sim.log"
  exit 1
}
